// ==== verilog/ping_macros.svh ====
// ping test subsystem constants
`ifndef PING_MACROS_SVH
`define PING_MACROS_SVH

// number of pinged peripherals
`define PING_N_ALERTS 4
`define PING_N_ESC 2

// wait and timeout counter width
`define PING_CNT_DW 8
`define PING_LFSR_DW 16

// lfsr reset state, never zero
`define PING_LFSR_SEED 16'hACE1
// galois feedback taps for x^16 + x^14 + x^13 + x^11 + 1
`define PING_LFSR_TAPS 16'hB400

// minimum spacing between pings
`define PING_MIN_WAIT 4

// register byte offsets
`define PING_ADDR_CTRL 8'h00
`define PING_ADDR_ALERT_EN 8'h04
`define PING_ADDR_TIMEOUT 8'h08
`define PING_ADDR_WAIT_MASK 8'h0C
`define PING_ADDR_ALERT_FAILS 8'h10
`define PING_ADDR_ESC_FAILS 8'h14

`endif

// ==== verilog/ping_bus_pkg.sv ====
// register bus types
`default_nettype none

package ping_bus_pkg;

  // byte address inside the register window
  typedef logic [7:0] addr_t;

  // one register word
  typedef logic [31:0] data_t;

  // axi response code
  typedef logic [1:0] resp_t;

  // decoded address
  localparam resp_t RESP_OKAY = 2'b00;
  // unmapped address, nothing changes
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== verilog/ping_core_pkg.sv ====
// ping logic types
`default_nettype none
`include "ping_macros.svh"

package ping_core_pkg;

  // wait and timeout counter value
  typedef logic [`PING_CNT_DW-1:0] cnt_t;

  // one bit per alert receiver / escalation sender
  typedef logic [`PING_N_ALERTS-1:0] alert_vec_t;
  typedef logic [`PING_N_ESC-1:0] esc_vec_t;

  // index of the pinged peripheral
  typedef logic [$clog2(`PING_N_ALERTS)-1:0] alert_id_t;
  typedef logic [$clog2(`PING_N_ESC)-1:0] esc_id_t;

  // prng state
  typedef logic [`PING_LFSR_DW-1:0] lfsr_t;

  // sparse encoding, codewords of a [6,3] code
  // any two states differ in at least 3 bits
  typedef enum logic [5:0] {
    INIT       = 6'b100110,
    ALERT_WAIT = 6'b010101,
    ALERT_PING = 6'b001011,
    ESC_WAIT   = 6'b110011,
    ESC_PING   = 6'b101101,
    FSM_ERROR  = 6'b011110
  } ping_state_e;

endpackage

`default_nettype wire

// ==== verilog/ping_reg_decode.sv ====
// ping register decode
`default_nettype none
`include "ping_macros.svh"

module ping_reg_decode (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  // axi4-lite slave
  input  wire ping_bus_pkg::addr_t                 s_awaddr_i,
  input  wire                                      s_awvalid_i,
  output logic                                     s_awready_o,
  input  wire ping_bus_pkg::data_t                 s_wdata_i,
  input  wire [$bits(ping_bus_pkg::data_t)/8-1:0]  s_wstrb_i,
  input  wire                                      s_wvalid_i,
  output logic                                     s_wready_o,
  output ping_bus_pkg::resp_t                      s_bresp_o,
  output logic                                     s_bvalid_o,
  input  wire                                      s_bready_i,
  input  wire ping_bus_pkg::addr_t                 s_araddr_i,
  input  wire                                      s_arvalid_i,
  output logic                                     s_arready_o,
  output ping_bus_pkg::data_t                      s_rdata_o,
  output ping_bus_pkg::resp_t                      s_rresp_o,
  output logic                                     s_rvalid_o,
  input  wire                                      s_rready_i,
  // configuration to the ping timer
  output logic                                     ping_en_o,
  output ping_core_pkg::alert_vec_t                alert_en_o,
  output ping_core_pkg::cnt_t                      timeout_cyc_o,
  output ping_core_pkg::cnt_t                      wait_mask_o,
  // fail log interface
  output logic                                     clr_alert_fails_o,
  output logic                                     clr_esc_fails_o,
  input  wire ping_bus_pkg::data_t                 alert_fails_i,
  input  wire ping_bus_pkg::data_t                 esc_fails_i
);

  localparam ping_core_pkg::cnt_t TIMEOUT_RST = ping_core_pkg::cnt_t'(16);

  logic                bus_rdy_q;
  logic                wr_acc;
  logic                wr_hit;
  logic                rd_acc;
  logic                rd_hit;
  ping_bus_pkg::data_t rd_data;

  // ready stays low during reset and one cycle after
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_rdy_q <= 1'b0;
    end else begin
      bus_rdy_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////

  // aw and w are taken together, blocked while a response waits
  assign s_awready_o = bus_rdy_q & ~s_bvalid_o;
  assign s_wready_o  = s_awready_o;
  assign wr_acc      = s_awvalid_i & s_wvalid_i & s_awready_o;

  assign wr_hit = s_awaddr_i inside {`PING_ADDR_CTRL, `PING_ADDR_ALERT_EN,
                                     `PING_ADDR_TIMEOUT, `PING_ADDR_WAIT_MASK,
                                     `PING_ADDR_ALERT_FAILS, `PING_ADDR_ESC_FAILS};

  // all configuration fields sit in byte lane 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ping_en_o     <= 1'b0;
      alert_en_o    <= '1;
      timeout_cyc_o <= TIMEOUT_RST;
      wait_mask_o   <= '1;
    end else if (wr_acc && s_wstrb_i[0]) begin
      case (s_awaddr_i)
        `PING_ADDR_CTRL:      ping_en_o     <= s_wdata_i[0];
        `PING_ADDR_ALERT_EN:  alert_en_o    <= s_wdata_i[`PING_N_ALERTS-1:0];
        `PING_ADDR_TIMEOUT:   timeout_cyc_o <= s_wdata_i[`PING_CNT_DW-1:0];
        `PING_ADDR_WAIT_MASK: wait_mask_o   <= s_wdata_i[`PING_CNT_DW-1:0];
        default: ;
      endcase
    end
  end

  // any write to a count clears it, whatever the data
  assign clr_alert_fails_o = wr_acc & (s_awaddr_i == `PING_ADDR_ALERT_FAILS);
  assign clr_esc_fails_o   = wr_acc & (s_awaddr_i == `PING_ADDR_ESC_FAILS);

  // bvalid rises the cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s_bvalid_o <= 1'b0;
    end else if (wr_acc) begin
      s_bvalid_o <= 1'b1;
    end else if (s_bready_i) begin
      s_bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      s_bresp_o <= wr_hit ? ping_bus_pkg::RESP_OKAY : ping_bus_pkg::RESP_SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  assign s_arready_o = bus_rdy_q & ~s_rvalid_o;
  assign rd_acc      = s_arvalid_i & s_arready_o;

  // register and counter readback mux
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (s_araddr_i)
      `PING_ADDR_CTRL:        rd_data = ping_bus_pkg::data_t'(ping_en_o);
      `PING_ADDR_ALERT_EN:    rd_data = ping_bus_pkg::data_t'(alert_en_o);
      `PING_ADDR_TIMEOUT:     rd_data = ping_bus_pkg::data_t'(timeout_cyc_o);
      `PING_ADDR_WAIT_MASK:   rd_data = ping_bus_pkg::data_t'(wait_mask_o);
      `PING_ADDR_ALERT_FAILS: rd_data = alert_fails_i;
      `PING_ADDR_ESC_FAILS:   rd_data = esc_fails_i;
      default:                rd_hit  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s_rvalid_o <= 1'b0;
    end else if (rd_acc) begin
      s_rvalid_o <= 1'b1;
    end else if (s_rready_i) begin
      s_rvalid_o <= 1'b0;
    end
  end

  // read data is sampled at acceptance
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_hit ? ping_bus_pkg::RESP_OKAY : ping_bus_pkg::RESP_SLVERR;
    end
  end

  // responses wait for the master
  a_bvalid_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o);
  a_rvalid_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o);

endmodule

`default_nettype wire

// ==== verilog/ping_timer.sv ====
// ping timer
`default_nettype none
`include "ping_macros.svh"

module ping_timer (
  input  wire                             clk_i,
  input  wire                             rst_ni,
  // configuration
  input  wire                             en_i,
  input  wire ping_core_pkg::alert_vec_t  alert_en_i,
  input  wire ping_core_pkg::cnt_t        timeout_cyc_i,
  input  wire ping_core_pkg::cnt_t        wait_mask_i,
  // ping requests and responses
  output ping_core_pkg::alert_vec_t       alert_ping_req_o,
  output ping_core_pkg::esc_vec_t         esc_ping_req_o,
  input  wire ping_core_pkg::alert_vec_t  alert_ping_ok_i,
  input  wire ping_core_pkg::esc_vec_t    esc_ping_ok_i,
  // one cycle fail pulses
  output logic                            alert_fail_o,
  output logic                            esc_fail_o
);

  localparam int unsigned ID_DW = $bits(ping_core_pkg::alert_id_t);

  ping_core_pkg::ping_state_e state_d;
  ping_core_pkg::ping_state_e state_q;

  ////////////////////////////////////////////////////////////
  // prng
  ////////////////////////////////////////////////////////////

  ping_core_pkg::lfsr_t      lfsr_q;
  ping_core_pkg::lfsr_t      lfsr_d;
  ping_core_pkg::alert_id_t  alert_id;
  logic                      id_vld;
  logic                      cnt_set;

  // galois form, shift right and fold the taps in on a one
  assign lfsr_d = lfsr_q[0] ? ((lfsr_q >> 1) ^ ping_core_pkg::lfsr_t'(`PING_LFSR_TAPS))
                            : (lfsr_q >> 1);

  // one step per counter load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= ping_core_pkg::lfsr_t'(`PING_LFSR_SEED);
    end else if (cnt_set) begin
      lfsr_q <= lfsr_d;
    end
  end

  // the bits above the wait value pick the alert
  assign alert_id = lfsr_q[`PING_CNT_DW +: ID_DW];
  // disabled alerts are skipped
  assign id_vld   = alert_en_i[alert_id];

  ////////////////////////////////////////////////////////////
  // wait / timeout counter
  ////////////////////////////////////////////////////////////

  ping_core_pkg::cnt_t  cnt_q;
  ping_core_pkg::cnt_t  wait_cyc;
  ping_core_pkg::cnt_t  cnt_load;
  logic                 wait_set;
  logic                 timeout_set;
  logic                 expired;

  assign expired  = (cnt_q == '0);
  assign cnt_set  = wait_set | timeout_set;
  // minimum spacing first, then the mask shortens the wait
  assign wait_cyc = (lfsr_q[`PING_CNT_DW-1:0] | ping_core_pkg::cnt_t'(`PING_MIN_WAIT))
                    & wait_mask_i;
  assign cnt_load = wait_set ? wait_cyc : timeout_cyc_i;

  // counts down and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_set) begin
      cnt_q <= cnt_load;
    end else if (!expired) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // escalation round robin and requests
  ////////////////////////////////////////////////////////////

  ping_core_pkg::esc_id_t  esc_idx_q;
  logic                    esc_step;
  logic                    alert_ping_en;
  logic                    esc_ping_en;
  logic                    alert_hit;
  logic                    esc_hit;
  logic                    alert_spur;
  logic                    esc_spur;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      esc_idx_q <= '0;
    end else if (esc_step) begin
      esc_idx_q <= (esc_idx_q == ping_core_pkg::esc_id_t'(`PING_N_ESC - 1)) ? '0
                                                                          : esc_idx_q + 1'b1;
    end
  end

  assign alert_ping_req_o = ping_core_pkg::alert_vec_t'(alert_ping_en) << alert_id;
  assign esc_ping_req_o   = ping_core_pkg::esc_vec_t'(esc_ping_en) << esc_idx_q;

  // matching response ends the ping
  assign alert_hit  = |(alert_ping_ok_i & alert_ping_req_o);
  assign esc_hit    = |(esc_ping_ok_i & esc_ping_req_o);
  // any response on a line that was not asked
  assign alert_spur = |(alert_ping_ok_i & ~alert_ping_req_o);
  assign esc_spur   = |(esc_ping_ok_i & ~esc_ping_req_o);

  ////////////////////////////////////////////////////////////
  // ping fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    wait_set      = 1'b0;
    timeout_set   = 1'b0;
    esc_step      = 1'b0;
    alert_ping_en = 1'b0;
    esc_ping_en   = 1'b0;
    alert_fail_o  = alert_spur;
    esc_fail_o    = esc_spur;
    case (state_q)
      // idle until enabled, never entered again
      ping_core_pkg::INIT: begin
        if (en_i) begin
          state_d  = ping_core_pkg::ALERT_WAIT;
          wait_set = 1'b1;
        end
      end
      ping_core_pkg::ALERT_WAIT: begin
        if (expired) begin
          state_d     = ping_core_pkg::ALERT_PING;
          timeout_set = 1'b1;
        end
      end
      // request held until response or timeout
      // a disabled id drops straight through
      ping_core_pkg::ALERT_PING: begin
        alert_ping_en = id_vld;
        if (expired || alert_hit || !id_vld) begin
          state_d  = ping_core_pkg::ESC_WAIT;
          wait_set = 1'b1;
          if (expired && id_vld) begin
            alert_fail_o = 1'b1;
          end
        end
      end
      ping_core_pkg::ESC_WAIT: begin
        if (expired) begin
          state_d     = ping_core_pkg::ESC_PING;
          timeout_set = 1'b1;
        end
      end
      ping_core_pkg::ESC_PING: begin
        esc_ping_en = 1'b1;
        if (expired || esc_hit) begin
          state_d  = ping_core_pkg::ALERT_WAIT;
          wait_set = 1'b1;
          esc_step = 1'b1;
          if (expired) begin
            esc_fail_o = 1'b1;
          end
        end
      end
      // terminal state, both fails stay high
      ping_core_pkg::FSM_ERROR: begin
        alert_fail_o = 1'b1;
        esc_fail_o   = 1'b1;
      end
      default: begin
        state_d      = ping_core_pkg::FSM_ERROR;
        alert_fail_o = 1'b1;
        esc_fail_o   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ping_core_pkg::INIT;
    end else begin
      state_q <= state_d;
    end
  end

  // only one ping in flight across both groups
  a_alert_req_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alert_ping_req_o));
  a_esc_req_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(esc_ping_req_o));
  a_req_exclusive : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((|alert_ping_req_o) && (|esc_ping_req_o)));

endmodule

`default_nettype wire

// ==== verilog/ping_fail_log.sv ====
// ping failure counters
`default_nettype none

module ping_fail_log (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // fail pulses from the timer
  input  wire                  alert_fail_i,
  input  wire                  esc_fail_i,
  // clear pulses from software
  input  wire                  clr_alert_i,
  input  wire                  clr_esc_i,
  output ping_bus_pkg::data_t  alert_fails_o,
  output ping_bus_pkg::data_t  esc_fails_o
);

  // index 0 counts alerts, index 1 escalations
  logic [1:0]           inc;
  logic [1:0]           clr;
  ping_bus_pkg::data_t  cnt_q [2];

  assign inc = {esc_fail_i, alert_fail_i};
  assign clr = {clr_esc_i, clr_alert_i};

  // clear wins over a pulse in the same cycle
  // counts stop at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (clr[i]) begin
          cnt_q[i] <= '0;
        end else if (inc[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign alert_fails_o = cnt_q[0];
  assign esc_fails_o   = cnt_q[1];

endmodule

`default_nettype wire

// ==== verilog/ping_top.sv ====
// ping test subsystem top
`default_nettype none

module ping_top (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  // axi4-lite slave
  input  wire ping_bus_pkg::addr_t                 s_awaddr_i,
  input  wire                                      s_awvalid_i,
  output logic                                     s_awready_o,
  input  wire ping_bus_pkg::data_t                 s_wdata_i,
  input  wire [$bits(ping_bus_pkg::data_t)/8-1:0]  s_wstrb_i,
  input  wire                                      s_wvalid_i,
  output logic                                     s_wready_o,
  output ping_bus_pkg::resp_t                      s_bresp_o,
  output logic                                     s_bvalid_o,
  input  wire                                      s_bready_i,
  input  wire ping_bus_pkg::addr_t                 s_araddr_i,
  input  wire                                      s_arvalid_i,
  output logic                                     s_arready_o,
  output ping_bus_pkg::data_t                      s_rdata_o,
  output ping_bus_pkg::resp_t                      s_rresp_o,
  output logic                                     s_rvalid_o,
  input  wire                                      s_rready_i,
  // pinged peripherals
  output ping_core_pkg::alert_vec_t                alert_ping_req_o,
  output ping_core_pkg::esc_vec_t                  esc_ping_req_o,
  input  wire ping_core_pkg::alert_vec_t           alert_ping_ok_i,
  input  wire ping_core_pkg::esc_vec_t             esc_ping_ok_i
);

  logic                       ping_en;
  ping_core_pkg::alert_vec_t  alert_en;
  ping_core_pkg::cnt_t        timeout_cyc;
  ping_core_pkg::cnt_t        wait_mask;
  logic                       clr_alert_fails;
  logic                       clr_esc_fails;
  logic                       alert_fail;
  logic                       esc_fail;
  ping_bus_pkg::data_t        alert_fails;
  ping_bus_pkg::data_t        esc_fails;

  // bus and clock ports connect by name
  ping_reg_decode u_reg_decode (
    .ping_en_o         (ping_en),
    .alert_en_o        (alert_en),
    .timeout_cyc_o     (timeout_cyc),
    .wait_mask_o       (wait_mask),
    .clr_alert_fails_o (clr_alert_fails),
    .clr_esc_fails_o   (clr_esc_fails),
    .alert_fails_i     (alert_fails),
    .esc_fails_i       (esc_fails),
    .*
  );

  ping_timer u_timer (
    .en_i          (ping_en),
    .alert_en_i    (alert_en),
    .timeout_cyc_i (timeout_cyc),
    .wait_mask_i   (wait_mask),
    .alert_fail_o  (alert_fail),
    .esc_fail_o    (esc_fail),
    .*
  );

  ping_fail_log u_fail_log (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .alert_fail_i  (alert_fail),
    .esc_fail_i    (esc_fail),
    .clr_alert_i   (clr_alert_fails),
    .clr_esc_i     (clr_esc_fails),
    .alert_fails_o (alert_fails),
    .esc_fails_o   (esc_fails)
  );

endmodule

`default_nettype wire

// ==== bench/ping_tb.sv ====
// ping subsystem testbench
`default_nettype none
`include "ping_macros.svh"

module ping_tb;

  localparam int unsigned WAIT_LIMIT = 400;
  localparam int unsigned N_ROWS     = 5;

  // responder modes
  localparam int MODE_ANSWER   = 0;
  localparam int MODE_NO_ALERT = 1;
  localparam int MODE_NO_ESC   = 2;
  localparam int MODE_SPURIOUS = 3;

  // kind of the last ping seen
  localparam int KIND_NONE  = 0;
  localparam int KIND_ALERT = 1;
  localparam int KIND_ESC   = 2;

  // axi response codes
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  typedef struct {
    ping_core_pkg::alert_vec_t alert_en;
    ping_core_pkg::cnt_t       timeout;
    ping_core_pkg::cnt_t       wait_mask;
    int                        mode;
    int                        esc_pings;
  } row_t;

  logic                       clk_i;
  logic                       rst_ni;
  ping_bus_pkg::addr_t        s_awaddr_i;
  logic                       s_awvalid_i;
  logic                       s_awready_o;
  ping_bus_pkg::data_t        s_wdata_i;
  logic [3:0]                 s_wstrb_i;
  logic                       s_wvalid_i;
  logic                       s_wready_o;
  ping_bus_pkg::resp_t        s_bresp_o;
  logic                       s_bvalid_o;
  logic                       s_bready_i;
  ping_bus_pkg::addr_t        s_araddr_i;
  logic                       s_arvalid_i;
  logic                       s_arready_o;
  ping_bus_pkg::data_t        s_rdata_o;
  ping_bus_pkg::resp_t        s_rresp_o;
  logic                       s_rvalid_o;
  logic                       s_rready_i;
  ping_core_pkg::alert_vec_t  alert_ping_req_o;
  ping_core_pkg::esc_vec_t    esc_ping_req_o;
  ping_core_pkg::alert_vec_t  alert_ping_ok_i;
  ping_core_pkg::esc_vec_t    esc_ping_ok_i;

  row_t rows [N_ROWS];

  // error counts
  int unsigned err_cnt;
  int unsigned tmo_cnt;

  // shared between the sequence and the responder
  int                         resp_mode;
  logic                       observing;
  int                         last_kind;
  ping_core_pkg::alert_vec_t  cur_alert_en;
  int unsigned                exp_alert_fails;
  int unsigned                exp_esc_fails;
  int unsigned                esc_seen;

  ping_top ping_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      err_cnt++;
      $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    tmo_cnt++;
    $display("timeout: %s", what);
  endtask

  task automatic axi_write(input ping_bus_pkg::addr_t addr, input ping_bus_pkg::data_t data,
                           output ping_bus_pkg::resp_t resp);
    int unsigned n;
    int unsigned delay;
    resp = 'x;
    @(posedge clk_i);
    #2;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    n = 0;
    while (!(s_awready_o && s_wready_o) && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    // aw and w both taken on this edge
    @(posedge clk_i);
    #2;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    if (n >= WAIT_LIMIT) begin
      note_timeout("write address and data were never accepted");
      return;
    end
    // random back-pressure on b
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk_i);
      #2;
    end
    s_bready_i = 1'b1;
    n = 0;
    while (!s_bvalid_o && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      note_timeout("no write response arrived");
    end else begin
      resp = s_bresp_o;
    end
    @(posedge clk_i);
    #2;
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input ping_bus_pkg::addr_t addr, output ping_bus_pkg::data_t data,
                          output ping_bus_pkg::resp_t resp);
    int unsigned n;
    int unsigned delay;
    data = 'x;
    resp = 'x;
    @(posedge clk_i);
    #2;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    n = 0;
    while (!s_arready_o && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    @(posedge clk_i);
    #2;
    s_arvalid_i = 1'b0;
    if (n >= WAIT_LIMIT) begin
      note_timeout("read address was never accepted");
      return;
    end
    // random back-pressure on r
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk_i);
      #2;
    end
    s_rready_i = 1'b1;
    n = 0;
    while (!s_rvalid_o && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      note_timeout("no read data arrived");
    end else begin
      data = s_rdata_o;
      resp = s_rresp_o;
    end
    @(posedge clk_i);
    #2;
    s_rready_i = 1'b0;
  endtask

  task automatic write_reg(input ping_bus_pkg::addr_t addr, input ping_bus_pkg::data_t data);
    ping_bus_pkg::resp_t resp;
    axi_write(addr, data, resp);
    check_val("s_bresp_o", 32'(OKAY), 32'(resp));
  endtask

  task automatic read_check(input ping_bus_pkg::addr_t addr, input logic [31:0] exp,
                            input string name);
    ping_bus_pkg::data_t data;
    ping_bus_pkg::resp_t resp;
    axi_read(addr, data, resp);
    check_val("s_rresp_o", 32'(OKAY), 32'(resp));
    check_val(name, exp, data);
  endtask

  ////////////////////////////////////////////////////////////
  // peripheral responder
  ////////////////////////////////////////////////////////////

  // answers pings per mode and keeps the expected fail counts
  initial begin : responder
    logic        in_ping;
    logic        refuse;
    int unsigned delay;
    int unsigned idx;
    ping_core_pkg::esc_vec_t exp_esc;
    alert_ping_ok_i = '0;
    esc_ping_ok_i   = '0;
    in_ping = 1'b0;
    refuse  = 1'b0;
    delay   = 0;
    forever begin
      @(posedge clk_i);
      #2;
      alert_ping_ok_i = '0;
      esc_ping_ok_i   = '0;
      // one ping in flight at most
      assert ($onehot0({alert_ping_req_o, esc_ping_req_o})) else begin
        err_cnt++;
        $display("ERR alert_ping_req_o / esc_ping_req_o: 0x%0h / 0x%0h not one-hot",
                 alert_ping_req_o, esc_ping_req_o);
      end
      if ((|alert_ping_req_o) || (|esc_ping_req_o)) begin
        if (!in_ping) begin
          in_ping = 1'b1;
          delay   = $urandom_range(2, 0);
          if (|alert_ping_req_o) begin
            assert (!observing || (alert_ping_req_o & ~cur_alert_en) == '0) else begin
              err_cnt++;
              $display("ERR alert_ping_req_o: 0x%0h outside enable mask 0x%0h",
                       alert_ping_req_o, cur_alert_en);
            end
            assert (last_kind != KIND_ALERT) else begin
              err_cnt++;
              $display("two alert pings followed each other with no escalation ping");
            end
            refuse = (resp_mode == MODE_NO_ALERT);
            if (refuse) begin
              exp_alert_fails++;
            end
            last_kind = KIND_ALERT;
          end else begin
            // round robin counted from enable
            exp_esc = ping_core_pkg::esc_vec_t'(1 << (esc_seen % `PING_N_ESC));
            check_val("esc_ping_req_o", 32'(exp_esc), 32'(esc_ping_req_o));
            // with every alert enabled no alert slot is skipped
            assert (!(observing && cur_alert_en == '1 && last_kind == KIND_ESC)) else begin
              err_cnt++;
              $display("two escalation pings followed each other with all alerts enabled");
            end
            refuse = (resp_mode == MODE_NO_ESC);
            if (refuse) begin
              exp_esc_fails++;
            end
            esc_seen++;
            last_kind = KIND_ESC;
          end
        end
        if (!refuse) begin
          if (delay == 0) begin
            alert_ping_ok_i = alert_ping_req_o;
            esc_ping_ok_i   = esc_ping_req_o;
          end else begin
            delay--;
          end
        end
      end else begin
        in_ping = 1'b0;
        // unrequested answer, one fail per cycle held
        if (resp_mode == MODE_SPURIOUS && $urandom_range(3, 0) == 0) begin
          if ($urandom_range(1, 0) == 0) begin
            idx = $urandom_range(`PING_N_ALERTS - 1, 0);
            alert_ping_ok_i[idx] = 1'b1;
            exp_alert_fails++;
          end else begin
            idx = $urandom_range(`PING_N_ESC - 1, 0);
            esc_ping_ok_i[idx] = 1'b1;
            exp_esc_fails++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    int unsigned n;
    int unsigned target;
    // configure while every ping is answered
    write_reg(`PING_ADDR_ALERT_EN, ping_bus_pkg::data_t'(rows[r].alert_en));
    write_reg(`PING_ADDR_TIMEOUT, ping_bus_pkg::data_t'(rows[r].timeout));
    write_reg(`PING_ADDR_WAIT_MASK, ping_bus_pkg::data_t'(rows[r].wait_mask));
    cur_alert_en = rows[r].alert_en;
    write_reg(`PING_ADDR_ALERT_FAILS, 32'h0);
    write_reg(`PING_ADDR_ESC_FAILS, 32'h0);
    @(negedge clk_i);
    exp_alert_fails = 0;
    exp_esc_fails   = 0;
    last_kind       = KIND_NONE;
    observing       = 1'b1;
    resp_mode       = rows[r].mode;
    target = esc_seen + rows[r].esc_pings;
    n = 0;
    while (esc_seen < target && n < 200 * rows[r].esc_pings) begin
      @(negedge clk_i);
      n++;
    end
    if (esc_seen < target) begin
      note_timeout("escalation pings stopped appearing");
    end
    // let the last ping end, answered or timed out
    resp_mode = MODE_ANSWER;
    observing = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (((|alert_ping_req_o) || (|esc_ping_req_o)) && n < WAIT_LIMIT);
    if (n >= WAIT_LIMIT) begin
      note_timeout("a ping request never ended");
    end
    $display("row %0d: expecting %0d alert and %0d escalation fails", r,
             exp_alert_fails, exp_esc_fails);
    read_check(`PING_ADDR_ALERT_FAILS, exp_alert_fails, "s_rdata_o alert fails");
    read_check(`PING_ADDR_ESC_FAILS, exp_esc_fails, "s_rdata_o escalation fails");
    // any write clears a count
    write_reg(`PING_ADDR_ALERT_FAILS, 32'hffff_ffff);
    write_reg(`PING_ADDR_ESC_FAILS, 32'h5a5a_5a5a);
    read_check(`PING_ADDR_ALERT_FAILS, 32'h0, "s_rdata_o alert fails cleared");
    read_check(`PING_ADDR_ESC_FAILS, 32'h0, "s_rdata_o escalation fails cleared");
  endtask

  initial begin : sequence_main
    ping_bus_pkg::resp_t resp;
    ping_bus_pkg::data_t rdata;
    void'($urandom(32'heefe_a695));
    // alert mask, timeout, wait mask, responder mode, escalation pings
    rows[0] = '{4'hF, 8'd12, 8'h0F, MODE_ANSWER,   4};
    rows[1] = '{4'h5, 8'd10, 8'h07, MODE_NO_ALERT, 4};
    rows[2] = '{4'h0, 8'd9,  8'h1F, MODE_NO_ESC,   3};
    rows[3] = '{4'hA, 8'd14, 8'h0F, MODE_SPURIOUS, 4};
    rows[4] = '{4'hF, 8'd8,  8'h03, MODE_NO_ALERT, 3};
    err_cnt         = 0;
    tmo_cnt         = 0;
    resp_mode       = MODE_ANSWER;
    observing       = 1'b0;
    last_kind       = KIND_NONE;
    cur_alert_en    = '1;
    exp_alert_fails = 0;
    exp_esc_fails   = 0;
    esc_seen        = 0;
    rst_ni      = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = 4'hF;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    // bus handshakes and ping requests stay quiet in reset
    check_val("s_awready_o", 32'h0, 32'(s_awready_o));
    check_val("s_wready_o", 32'h0, 32'(s_wready_o));
    check_val("s_arready_o", 32'h0, 32'(s_arready_o));
    check_val("s_bvalid_o", 32'h0, 32'(s_bvalid_o));
    check_val("s_rvalid_o", 32'h0, 32'(s_rvalid_o));
    check_val("alert_ping_req_o", 32'h0, 32'(alert_ping_req_o));
    check_val("esc_ping_req_o", 32'h0, 32'(esc_ping_req_o));
    rst_ni = 1'b1;

    // reset values
    read_check(`PING_ADDR_CTRL, 32'h0, "s_rdata_o ctrl");
    read_check(`PING_ADDR_ALERT_EN, 32'hF, "s_rdata_o alert enable");
    read_check(`PING_ADDR_TIMEOUT, 32'd16, "s_rdata_o timeout");
    read_check(`PING_ADDR_WAIT_MASK, 32'hFF, "s_rdata_o wait mask");
    read_check(`PING_ADDR_ALERT_FAILS, 32'h0, "s_rdata_o alert fails");

    // write and readback, then unmapped offsets
    write_reg(`PING_ADDR_ALERT_EN, 32'h9);
    read_check(`PING_ADDR_ALERT_EN, 32'h9, "s_rdata_o alert enable");
    write_reg(`PING_ADDR_TIMEOUT, 32'h2C);
    read_check(`PING_ADDR_TIMEOUT, 32'h2C, "s_rdata_o timeout");
    write_reg(`PING_ADDR_WAIT_MASK, 32'h3C);
    read_check(`PING_ADDR_WAIT_MASK, 32'h3C, "s_rdata_o wait mask");
    axi_write(8'h18, 32'h1234_5678, resp);
    check_val("s_bresp_o", 32'(SLVERR), 32'(resp));
    axi_read(8'h1C, rdata, resp);
    check_val("s_rresp_o", 32'(SLVERR), 32'(resp));
    read_check(`PING_ADDR_TIMEOUT, 32'h2C, "s_rdata_o timeout after unmapped write");

    // start pinging, it never stops after this
    write_reg(`PING_ADDR_CTRL, 32'h1);
    read_check(`PING_ADDR_CTRL, 32'h1, "s_rdata_o ctrl");
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end

    $display("errors: %0d wrong values, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/ping_bus_pkg.sv
verilog/ping_core_pkg.sv
verilog/ping_reg_decode.sv
verilog/ping_timer.sv
verilog/ping_fail_log.sv
verilog/ping_top.sv
bench/ping_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ping subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ping_tb -f vlog.f --Mdir obj_dir -o ping_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/ping_sim > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$log_file"; then
  echo "simulation reported failing checks"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log_file"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
